/* hw/tdc_types_pkg.sv */
package tdc_types_pkg;

	localparam int ID_W     = 4;
	localparam int TYPE_W   = 3;
	localparam int STATE_W  = 4;
	localparam int COARSE_W = 16;
	localparam int FINE_W   = 2;
	localparam int TDL_W    = 7;
	localparam int TS_W     = 25;

	typedef enum logic [STATE_W-1:0] {
		IDLE      = 4'd0,
		IDLE_TRIG = 4'd1,
		TRIGGERED = 4'd2,
		RIS_EDGE  = 4'd3,
		FAL_EDGE  = 4'd4,
		MISSED    = 4'd5,
		CALIB     = 4'd6,
		CALIB_HIT = 4'd7,
		RESET     = 4'd8
	} tdc_state_e;

	typedef enum logic [TYPE_W-1:0] {
		TRIGGERED_WORD = 3'd0,
		RISING_WORD    = 3'd1,
		FALLING_WORD   = 3'd2,
		TIMESTAMP_WORD = 3'd3,
		CALIB_WORD     = 3'd4,
		MISS_WORD      = 3'd5,
		RESET_WORD     = 3'd6
	} word_type_e;

	// time payload with msb first
	typedef struct packed {
		logic [COARSE_W-1:0] coarse;
		logic [FINE_W-1:0]   fine;
		logic [TDL_W-1:0]    tdl;
	} tdc_time_t;

	typedef struct packed {
		logic [ID_W-1:0] id;
		word_type_e      wtype;
		logic [TS_W-1:0] payload;
	} tdc_word_t;

endpackage

/* hw/tdc_cfg_pkg.sv */
package tdc_cfg_pkg;

	localparam int CFG_ADDR_W = 2;
	localparam int CFG_DATA_W = 8;

	typedef enum logic [CFG_ADDR_W-1:0] {
		CFG_CTRL = 2'd0,
		CFG_CMD  = 2'd1
	} cfg_addr_e;

	// control register bits
	typedef struct packed {
		logic en_write_timestamp;
		logic calib_mode;
	} tdc_cfg_t;

endpackage

/* hw/tdc_config_regs.sv */
`timescale 1ns/1ps

module tdc_config_regs
	import tdc_cfg_pkg::*;
(
	input  logic                  CLK,
	input  logic                  rst_n,
	input  logic                  cfg_we,
	input  cfg_addr_e             cfg_addr,
	input  logic [CFG_DATA_W-1:0] cfg_wdata,
	output tdc_cfg_t              cfg,
	output logic                  reset_cmd
);

	logic ctrl_wr;
	logic cmd_wr;

	assign ctrl_wr = cfg_we && (cfg_addr == CFG_CTRL);
	assign cmd_wr  = cfg_we && (cfg_addr == CFG_CMD);

	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			cfg <= '0;
		end else if (ctrl_wr) begin
			cfg.en_write_timestamp <= cfg_wdata[0];
			cfg.calib_mode         <= cfg_wdata[1];
		end
	end

	// command bits self-clear after one cycle
	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			reset_cmd <= 1'b0;
		end else begin
			reset_cmd <= cmd_wr && cfg_wdata[0];
		end
	end

endmodule

/* hw/tdc_time_base.sv */
`timescale 1ns/1ps

module tdc_time_base
	import tdc_types_pkg::*;
(
	input  logic                CLK,
	input  logic                rst_n,
	input  logic                clear_coarse,
	input  logic                reset_cmd,
	input  logic                rise_capture,
	output logic [COARSE_W-1:0] coarse,
	output logic [TS_W-1:0]     signal_timestamp,
	output logic [TS_W-1:0]     reset_timestamp
);

	logic [TS_W-1:0] timestamp;

	// coarse stops counting once the msb is reached
	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			coarse    <= '0;
			timestamp <= '0;
		end else begin
			if (reset_cmd || clear_coarse)
				coarse <= '0;
			else if (!coarse[COARSE_W-1])
				coarse <= coarse + 1'b1;

			if (reset_cmd)
				timestamp <= '0;
			else
				timestamp <= timestamp + 1'b1;
		end
	end

	always_ff @(posedge CLK) begin
		if (rise_capture)
			signal_timestamp <= timestamp;
		if (reset_cmd)
			reset_timestamp <= timestamp;
	end

endmodule

/* hw/tdc_channel_fsm.sv */
`timescale 1ns/1ps

module tdc_channel_fsm
	import tdc_types_pkg::*;
	import tdc_cfg_pkg::*;
(
	input  logic       CLK,
	input  logic       rst_n,
	input  logic       hit,
	input  logic       trigger,
	input  tdc_cfg_t   cfg,
	input  logic       reset_cmd,
	input  logic       fifo_room,
	output tdc_state_e tdc_state,
	output logic       clear_coarse,
	output logic       rise_capture
);

	logic [1:0] hit_sync;
	logic       hit_rise;
	logic       hit_fall;
	tdc_state_e state_nxt;

	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			hit_sync  <= 2'b00;
			tdc_state <= IDLE;
		end else begin
			hit_sync  <= {hit_sync[0], hit};
			tdc_state <= state_nxt;
		end
	end

	assign hit_rise = hit_sync[0] & ~hit_sync[1];
	assign hit_fall = ~hit_sync[0] & hit_sync[1];

	always_comb begin
		state_nxt = tdc_state;
		case (tdc_state)
			IDLE: begin
				if (reset_cmd)
					state_nxt = RESET;
				else if (cfg.calib_mode)
					state_nxt = CALIB;
				else if (trigger)
					state_nxt = IDLE_TRIG;
				else if (hit_rise)
					state_nxt = fifo_room ? RIS_EDGE : MISSED;
			end
			IDLE_TRIG: state_nxt = TRIGGERED;
			TRIGGERED: if (hit_rise) state_nxt = RIS_EDGE;
			RIS_EDGE:  if (hit_fall) state_nxt = FAL_EDGE;
			FAL_EDGE:  state_nxt = IDLE;
			MISSED:    state_nxt = IDLE;
			RESET:     state_nxt = IDLE;
			// leaving calibration mode drops back to idle
			CALIB: begin
				if (hit_rise)
					state_nxt = CALIB_HIT;
				else if (!cfg.calib_mode)
					state_nxt = IDLE;
			end
			CALIB_HIT: state_nxt = IDLE;
			default:   state_nxt = IDLE;
		endcase
	end

	assign clear_coarse = (tdc_state == IDLE_TRIG && state_nxt == TRIGGERED) ||
		(tdc_state == IDLE && state_nxt == RIS_EDGE);
	assign rise_capture = (state_nxt == RIS_EDGE) && (tdc_state != RIS_EDGE);

endmodule

/* hw/word_broker.sv */
`timescale 1ns/1ps

module word_broker
	import tdc_types_pkg::*;
#(
	parameter logic [ID_W-1:0] DATA_IDENTIFIER = 4'b0100
)(
	input  logic            CLK,
	input  logic            rst_n,
	input  tdc_state_e      tdc_state,
	input  tdc_time_t       time_in,
	input  logic            en_write_timestamp,
	input  logic [TS_W-1:0] signal_timestamp,
	input  logic [TS_W-1:0] reset_timestamp,
	output logic            word_valid,
	output tdc_word_t       word
);

	tdc_state_e      prev_state;
	logic            valid_nxt;
	word_type_e      type_nxt;
	logic [TS_W-1:0] payload_nxt;
	logic [TS_W-1:0] sat_payload;

	// saturated coarse and fine with tdl kept as measured
	assign sat_payload = {{COARSE_W{1'b1}}, {FINE_W{1'b1}}, time_in.tdl};

	always_comb begin
		valid_nxt   = 1'b1;
		type_nxt    = TRIGGERED_WORD;
		payload_nxt = time_in;
		case ({prev_state, tdc_state})
			{IDLE_TRIG, TRIGGERED}: type_nxt = TRIGGERED_WORD;
			{IDLE, RIS_EDGE}:       type_nxt = RISING_WORD;
			{TRIGGERED, RIS_EDGE}: begin
				type_nxt = RISING_WORD;
				if (time_in.coarse[COARSE_W-1])
					payload_nxt = sat_payload;
			end
			{RIS_EDGE, FAL_EDGE}: begin
				type_nxt = FALLING_WORD;
				if (time_in.coarse[COARSE_W-1])
					payload_nxt = sat_payload;
			end
			{FAL_EDGE, IDLE}, {FAL_EDGE, IDLE_TRIG}: begin
				valid_nxt   = en_write_timestamp;
				type_nxt    = TIMESTAMP_WORD;
				payload_nxt = signal_timestamp;
			end
			{MISSED, IDLE}: begin
				type_nxt    = MISS_WORD;
				payload_nxt = '0;
			end
			{RESET, IDLE}: begin
				type_nxt    = RESET_WORD;
				payload_nxt = reset_timestamp;
			end
			{CALIB, CALIB_HIT}: begin
				type_nxt    = CALIB_WORD;
				payload_nxt = {{COARSE_W{1'b0}}, time_in.fine, time_in.tdl};
			end
			default: valid_nxt = 1'b0;
		endcase
	end

	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			prev_state <= IDLE;
			word_valid <= 1'b0;
		end else begin
			prev_state <= tdc_state;
			word_valid <= valid_nxt;
		end
	end

	always_ff @(posedge CLK) begin
		word.id      <= DATA_IDENTIFIER;
		word.wtype   <= type_nxt;
		word.payload <= payload_nxt;
	end

endmodule

/* hw/word_credit_fifo.sv */
`timescale 1ns/1ps

module word_credit_fifo
	import tdc_types_pkg::*;
#(
	parameter int FIFO_DEPTH   = 8,
	parameter int INIT_CREDITS = 4
)(
	input  logic      CLK,
	input  logic      rst_n,
	input  logic      word_valid,
	input  tdc_word_t word,
	output logic      fifo_room,
	input  logic      credit_return,
	output logic      out_valid,
	output tdc_word_t out_word
);

	localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
	localparam int CNT_W = $clog2(FIFO_DEPTH + 1);
	localparam int CRD_W = $clog2(INIT_CREDITS + 1);

	tdc_word_t        mem [FIFO_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic [CRD_W-1:0] credits;
	logic             empty;
	logic             pop;
	logic             pop_mem;
	logic             store;

	function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
		return (ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign empty     = (count == '0);
	assign fifo_room = (count <= CNT_W'(FIFO_DEPTH - 2));
	// an incoming word bypasses an empty buffer
	assign pop       = (credits != '0) && (!empty || word_valid);
	assign pop_mem   = pop && !empty;
	assign store     = word_valid && !(pop && empty) &&
		((count != CNT_W'(FIFO_DEPTH)) || pop_mem);

	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			wr_ptr    <= '0;
			rd_ptr    <= '0;
			count     <= '0;
			credits   <= CRD_W'(INIT_CREDITS);
			out_valid <= 1'b0;
		end else begin
			if (store)
				wr_ptr <= ptr_inc(wr_ptr);
			if (pop_mem)
				rd_ptr <= ptr_inc(rd_ptr);
			count     <= count + CNT_W'(store) - CNT_W'(pop_mem);
			credits   <= credits + CRD_W'(credit_return) - CRD_W'(pop);
			out_valid <= pop;
		end
	end

	always_ff @(posedge CLK) begin
		if (store)
			mem[wr_ptr] <= word;
		if (pop)
			out_word <= empty ? word : mem[rd_ptr];
	end

endmodule

/* hw/tdc_readout_top.sv */
`timescale 1ns/1ps

module tdc_readout_top
	import tdc_types_pkg::*;
	import tdc_cfg_pkg::*;
#(
	parameter logic [ID_W-1:0] DATA_IDENTIFIER = 4'b0100,
	parameter int              FIFO_DEPTH      = 8,
	parameter int              INIT_CREDITS    = 4
)(
	input  logic                  CLK,
	input  logic                  rst_n,
	input  logic                  hit,
	input  logic                  trigger,
	input  logic [TDL_W-1:0]      tdl_code,
	input  logic [FINE_W-1:0]     fine_phase,
	input  logic                  cfg_we,
	input  cfg_addr_e             cfg_addr,
	input  logic [CFG_DATA_W-1:0] cfg_wdata,
	input  logic                  credit_return,
	output logic                  out_valid,
	output tdc_word_t             out_word
);

	tdc_cfg_t            cfg;
	logic                reset_cmd;
	logic                clear_coarse;
	logic                rise_capture;
	logic                fifo_room;
	logic [COARSE_W-1:0] coarse;
	logic [TS_W-1:0]     signal_timestamp;
	logic [TS_W-1:0]     reset_timestamp;
	tdc_state_e          tdc_state;
	tdc_time_t           time_in;
	logic                word_valid;
	tdc_word_t           word;

	assign time_in.coarse = coarse;
	assign time_in.fine   = fine_phase;
	assign time_in.tdl    = tdl_code;

	tdc_config_regs regs_i (
		.CLK, .rst_n, .cfg_we, .cfg_addr, .cfg_wdata, .cfg, .reset_cmd
	);

	tdc_time_base time_i (
		.CLK, .rst_n, .clear_coarse, .reset_cmd, .rise_capture,
		.coarse, .signal_timestamp, .reset_timestamp
	);

	tdc_channel_fsm fsm_i (
		.CLK, .rst_n, .hit, .trigger, .cfg, .reset_cmd, .fifo_room,
		.tdc_state, .clear_coarse, .rise_capture
	);

	word_broker #(.DATA_IDENTIFIER(DATA_IDENTIFIER)) broker_i (
		.CLK, .rst_n, .tdc_state, .time_in,
		.en_write_timestamp(cfg.en_write_timestamp),
		.signal_timestamp, .reset_timestamp, .word_valid, .word
	);

	word_credit_fifo #(
		.FIFO_DEPTH(FIFO_DEPTH),
		.INIT_CREDITS(INIT_CREDITS)
	) fifo_i (
		.CLK, .rst_n, .word_valid, .word, .fifo_room, .credit_return,
		.out_valid, .out_word
	);

endmodule

/* sim/tdc_readout_tb.sv */
`timescale 1ns/1ps

module tdc_readout_tb
	import tdc_types_pkg::*;
	import tdc_cfg_pkg::*;
();

	localparam int              CLK_PERIOD   = 4;
	localparam logic [ID_W-1:0] DATA_ID      = 4'b0100;
	localparam int              INIT_CREDITS = 4;
	localparam int              OVF_GAP      = 2**15 + 8;
	localparam int              DRAIN_LIMIT  = 400;
	// overflow wait plus a margin for the short tests
	localparam int              RUN_LIMIT    = OVF_GAP + 4000;

	logic                  CLK;
	logic                  rst_n;
	logic                  hit;
	logic                  trigger;
	logic [TDL_W-1:0]      tdl_code;
	logic [FINE_W-1:0]     fine_phase;
	logic                  cfg_we;
	cfg_addr_e             cfg_addr;
	logic [CFG_DATA_W-1:0] cfg_wdata;
	logic                  credit_return = 1'b0;
	logic                  out_valid;
	tdc_word_t             out_word;

	integer    seed = 32'h9590_a4ae;
	tdc_word_t exp_q[$];
	bit        chk_q[$];
	tdc_word_t last_word;
	int        rx_count = 0;
	int        cycle = 0;
	int        owed = 0;
	logic      credit_hold = 1'b0;
	bit        ts_enabled;

	tdc_readout_top dut_i (.*);

	initial begin
		CLK = 1'b0;
		forever #(CLK_PERIOD / 2) CLK = ~CLK;
	end

	initial begin
		#(RUN_LIMIT * CLK_PERIOD);
		$display("watchdog expired before the tests completed");
		$display("TESTS FAILED");
		$fatal(1, "simulation timeout");
	end

	task automatic fail_stop();
		$display("TESTS FAILED");
		$fatal(1, "stopping at the first error");
	endtask

	task automatic check_type(input string name, input word_type_e got, input word_type_e exp);
		if (got !== exp) begin
			$display("[FAIL] %0t ns %s: got %s (%0d), expected %s (%0d)", $time, name,
				got.name(), got, exp.name(), exp);
			fail_stop();
		end
	endtask

	task automatic check_word(input tdc_word_t got, input tdc_word_t exp);
		if (got.id !== exp.id) begin
			$display("[FAIL] %0t ns out_word.id: got %h, expected %h", $time, got.id, exp.id);
			fail_stop();
		end
		check_type("out_word.wtype", got.wtype, exp.wtype);
	endtask

	task automatic check_payload(input string name, input logic [TS_W-1:0] got,
		input logic [TS_W-1:0] exp);
		if (got !== exp) begin
			$display("[FAIL] %0t ns %s: got %h, expected %h", $time, name, got, exp);
			fail_stop();
		end
	endtask

	// scoreboard with one expected word per out_valid cycle
	always @(posedge CLK) begin : monitor
		tdc_word_t exp_w;
		bit        chk;
		cycle <= cycle + 1;
		if (rst_n && out_valid) begin
			if (exp_q.size() == 0) begin
				$display("word %h arrived at %0t ns when none was expected", out_word, $time);
				fail_stop();
			end else begin
				exp_w = exp_q.pop_front();
				chk   = chk_q.pop_front();
				check_word(out_word, exp_w);
				if (chk)
					check_payload("out_word.payload", out_word.payload, exp_w.payload);
				last_word <= out_word;
				rx_count  <= rx_count + 1;
			end
		end
	end

	// returns one credit per received word unless held
	always @(posedge CLK) begin
		if (!rst_n) begin
			owed = 0;
			credit_return <= 1'b0;
		end else begin
			if (out_valid)
				owed = owed + 1;
			if (!credit_hold && owed > 0) begin
				credit_return <= 1'b1;
				owed = owed - 1;
			end else begin
				credit_return <= 1'b0;
			end
		end
	end

	// coarse and fine go to all ones once the coarse msb would be set
	function automatic logic [TS_W-1:0] time_payload(input int cnt,
		input logic [FINE_W-1:0] fine, input logic [TDL_W-1:0] tdl);
		tdc_time_t t;
		if (cnt >= 2**(COARSE_W-1)) begin
			t.coarse = '1;
			t.fine   = '1;
		end else begin
			t.coarse = COARSE_W'(cnt);
			t.fine   = fine;
		end
		t.tdl = tdl;
		return t;
	endfunction

	task automatic expect_word(input word_type_e wtype, input logic [TS_W-1:0] payload,
		input bit chk);
		tdc_word_t w;
		w.id      = DATA_ID;
		w.wtype   = wtype;
		w.payload = payload;
		exp_q.push_back(w);
		chk_q.push_back(chk);
	endtask

	task automatic drive_pads(output logic [TDL_W-1:0] tdl, output logic [FINE_W-1:0] fine);
		tdl        = TDL_W'($random(seed));
		fine       = FINE_W'($random(seed));
		tdl_code   <= tdl;
		fine_phase <= fine;
	endtask

	task automatic write_cfg(input cfg_addr_e addr, input logic [CFG_DATA_W-1:0] data);
		@(posedge CLK);
		cfg_we    <= 1'b1;
		cfg_addr  <= addr;
		cfg_wdata <= data;
		@(posedge CLK);
		cfg_we <= 1'b0;
		repeat (3) @(posedge CLK);
	endtask

	task automatic wait_drain();
		int n;
		n = 0;
		while (exp_q.size() != 0) begin
			@(negedge CLK);
			n++;
			if (n > DRAIN_LIMIT) begin
				$display("%0d expected words never arrived", exp_q.size());
				fail_stop();
			end
		end
		// catches words that should not be there
		repeat (10) @(negedge CLK);
	endtask

	// optional trigger, gap cycles, then a hit of width cycles
	task automatic send_pulse(input bit with_trig, input int gap, input int width,
		input bit miss);
		logic [TDL_W-1:0]  tdl;
		logic [FINE_W-1:0] fine;
		int                rise_cnt;
		@(posedge CLK);
		rise_cnt = 0;
		if (with_trig) begin
			trigger <= 1'b1;
			drive_pads(tdl, fine);
			expect_word(TRIGGERED_WORD, time_payload(0, fine, tdl), 1'b1);
			@(posedge CLK);
			trigger <= 1'b0;
			repeat (gap) @(posedge CLK);
			rise_cnt = gap + 1;
		end
		hit <= 1'b1;
		drive_pads(tdl, fine);
		if (miss)
			expect_word(MISS_WORD, '0, 1'b1);
		else
			expect_word(RISING_WORD, time_payload(rise_cnt, fine, tdl), 1'b1);
		repeat (width) @(posedge CLK);
		hit <= 1'b0;
		drive_pads(tdl, fine);
		if (!miss) begin
			expect_word(FALLING_WORD, time_payload(rise_cnt + width, fine, tdl), 1'b1);
			if (ts_enabled)
				expect_word(TIMESTAMP_WORD, '0, 1'b0);
		end
		repeat (6) @(posedge CLK);
	endtask

	task automatic test_triggered_pulse();
		write_cfg(CFG_CTRL, 8'h01);
		ts_enabled = 1'b1;
		send_pulse(1'b1, 4, 6, 1'b0);
		wait_drain();
	endtask

	task automatic test_plain_pulse();
		write_cfg(CFG_CTRL, 8'h00);
		ts_enabled = 1'b0;
		send_pulse(1'b0, 0, 5, 1'b0);
		wait_drain();
	endtask

	task automatic test_calibration();
		logic [TDL_W-1:0]  tdl;
		logic [FINE_W-1:0] fine;
		tdc_time_t         t;
		write_cfg(CFG_CTRL, 8'h02);
		@(posedge CLK);
		hit <= 1'b1;
		drive_pads(tdl, fine);
		t.coarse = '0;
		t.fine   = fine;
		t.tdl    = tdl;
		expect_word(CALIB_WORD, t, 1'b1);
		repeat (4) @(posedge CLK);
		hit <= 1'b0;
		repeat (4) @(posedge CLK);
		write_cfg(CFG_CTRL, 8'h00);
		wait_drain();
	endtask

	task automatic test_reset_cmd();
		int t0;
		write_cfg(CFG_CTRL, 8'h01);
		ts_enabled = 1'b1;
		expect_word(RESET_WORD, '0, 1'b0);
		t0 = cycle;
		write_cfg(CFG_CMD, 8'h01);
		wait_drain();
		send_pulse(1'b0, 0, 4, 1'b0);
		wait_drain();
		if (int'(last_word.payload) >= cycle - t0 + 1) begin
			$display("timestamp %0d is not below the %0d cycles since the reset command",
				last_word.payload, cycle - t0 + 1);
			fail_stop();
		end
	endtask

	// 3 + 2*4 words minus 4 credits leave 7 buffered so the last hit is missed
	task automatic test_backpressure();
		int base;
		write_cfg(CFG_CTRL, 8'h00);
		ts_enabled = 1'b0;
		@(posedge CLK);
		credit_hold <= 1'b1;
		base = rx_count;
		send_pulse(1'b1, 3, 3, 1'b0);
		repeat (4) send_pulse(1'b0, 0, 3, 1'b0);
		send_pulse(1'b0, 0, 3, 1'b1);
		repeat (20) @(negedge CLK);
		if (rx_count - base > INIT_CREDITS) begin
			$display("%0d words sent with only %0d credits", rx_count - base, INIT_CREDITS);
			fail_stop();
		end
		@(posedge CLK);
		credit_hold <= 1'b0;
		wait_drain();
	endtask

	task automatic test_overflow();
		send_pulse(1'b1, OVF_GAP, 3, 1'b0);
		wait_drain();
	endtask

	initial begin
		rst_n      = 1'b0;
		hit        = 1'b0;
		trigger    = 1'b0;
		tdl_code   = '0;
		fine_phase = '0;
		cfg_we     = 1'b0;
		cfg_addr   = CFG_CTRL;
		cfg_wdata  = '0;
		ts_enabled = 1'b0;
		repeat (10) @(posedge CLK);
		rst_n <= 1'b1;
		repeat (3) @(posedge CLK);
		test_triggered_pulse();
		test_plain_pulse();
		test_calibration();
		test_reset_cmd();
		test_backpressure();
		test_overflow();
		$display("TESTS PASSED");
		$finish;
	end

endmodule

/* filelist.f */
hw/tdc_types_pkg.sv
hw/tdc_cfg_pkg.sv
hw/tdc_config_regs.sv
hw/tdc_time_base.sv
hw/tdc_channel_fsm.sv
hw/word_broker.sv
hw/word_credit_fifo.sv
hw/tdc_readout_top.sv
sim/tdc_readout_tb.sv

/* Bender.yml */
package:
  name: tdc_readout

sources:
  - hw/tdc_types_pkg.sv
  - hw/tdc_cfg_pkg.sv
  - hw/tdc_config_regs.sv
  - hw/tdc_time_base.sv
  - hw/tdc_channel_fsm.sv
  - hw/word_broker.sv
  - hw/word_credit_fifo.sv
  - hw/tdc_readout_top.sv
  - target: simulation
    files:
      - sim/tdc_readout_tb.sv
